//--- design/rv_decode_params.svh
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

`define RV_XLEN    32
`define ROB_ADDR_W 4

// RV32I major opcodes
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_JAL    7'b1101111
`define OPC_JALR   7'b1100111
`define OPC_LOAD   7'b0000011
`define OPC_IMM    7'b0010011
`define OPC_BRANCH 7'b1100011
`define OPC_STORE  7'b0100011
`define OPC_REG    7'b0110011

// internal op numbers, grouped so kind falls out of a range compare
`define OP_LUI   6'd1
`define OP_AUIPC 6'd2
`define OP_JAL   6'd3
`define OP_JALR  6'd4
`define OP_BEQ   6'd5
`define OP_BNE   6'd6
`define OP_BLT   6'd7
`define OP_BGE   6'd8
`define OP_BLTU  6'd9
`define OP_BGEU  6'd10
`define OP_LB    6'd11
`define OP_LH    6'd12
`define OP_LW    6'd13
`define OP_LBU   6'd14
`define OP_LHU   6'd15
`define OP_SB    6'd16
`define OP_SH    6'd17
`define OP_SW    6'd18
`define OP_ADDI  6'd19
`define OP_SLTI  6'd20
`define OP_SLTIU 6'd21
`define OP_XORI  6'd22
`define OP_ORI   6'd23
`define OP_ANDI  6'd24
`define OP_SLLI  6'd25
`define OP_SRLI  6'd26
`define OP_SRAI  6'd27
`define OP_ADD   6'd28
`define OP_SUB   6'd29
`define OP_SLL   6'd30
`define OP_SLT   6'd31
`define OP_SLTU  6'd32
`define OP_XOR   6'd33
`define OP_SRL   6'd34
`define OP_SRA   6'd35
`define OP_OR    6'd36
`define OP_AND   6'd37
`define OP_EXIT  6'd38

// ROB entry kinds
`define KIND_ELSE   3'd0
`define KIND_BRANCH 3'd1
`define KIND_LOAD   3'd2
`define KIND_STORE  3'd3
`define KIND_TOREG  3'd4
`define KIND_EXIT   3'd5

`endif

//--- design/rv_decode_pkg.sv
`default_nettype none
`include "rv_decode_params.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0] word_t;      // data or address word
    typedef logic [4:0] reg_idx_t;            // architectural register
    typedef logic [`ROB_ADDR_W-1:0] rob_idx_t;
    typedef logic [5:0] op_t;                 // internal op number
    typedef logic [2:0] rob_kind_t;

endpackage

`default_nettype wire

//--- design/field_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_params.svh"

module field_decode
    import rv_decode_pkg::*;
(
    input  word_t     instr,
    input  word_t     pc,
    input  logic      is_jump,
    output reg_idx_t  rs1,
    output reg_idx_t  rs2,
    output reg_idx_t  rd,
    output op_t       op,
    output rob_kind_t kind,
    output logic      uses_rs1,
    output logic      uses_rs2,
    output word_t     imm_operand,
    output word_t     store_offset,
    output logic      to_rs,
    output logic      to_lsb,
    output logic      result_ready,
    output word_t     result_value,
    output reg_idx_t  dest,
    output word_t     branch_target,
    output logic      rob_jump,
    output word_t     next_pc
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       alt;
    word_t      imm_u;
    word_t      imm_j;
    word_t      imm_i;
    word_t      imm_shamt;
    word_t      imm_b;
    word_t      pc_plus4;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign alt    = instr[30];      // sub / sra select
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    assign imm_u        = {instr[31:12], 12'b0};
    assign imm_j        = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_i        = {{20{instr[31]}}, instr[31:20]};
    assign imm_shamt    = {27'b0, instr[24:20]};
    assign imm_b        = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign store_offset = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc + imm_b;

    // shifts take a zero-extended shamt
    assign imm_operand = (opcode == `OPC_IMM && funct3[1:0] == 2'b01) ? imm_shamt : imm_i;

    always_comb begin
        op = `OP_EXIT;
        case (opcode)
            `OPC_LUI:   op = `OP_LUI;
            `OPC_AUIPC: op = `OP_AUIPC;
            `OPC_JAL:   op = `OP_JAL;
            `OPC_JALR:  op = `OP_JALR;
            `OPC_BRANCH: begin
                case (funct3)
                    3'b000:  op = `OP_BEQ;
                    3'b001:  op = `OP_BNE;
                    3'b100:  op = `OP_BLT;
                    3'b101:  op = `OP_BGE;
                    3'b110:  op = `OP_BLTU;
                    3'b111:  op = `OP_BGEU;
                    default: op = `OP_EXIT;
                endcase
            end
            `OPC_LOAD: begin
                case (funct3)
                    3'b000:  op = `OP_LB;
                    3'b001:  op = `OP_LH;
                    3'b010:  op = `OP_LW;
                    3'b100:  op = `OP_LBU;
                    3'b101:  op = `OP_LHU;
                    default: op = `OP_EXIT;
                endcase
            end
            `OPC_STORE: begin
                case (funct3)
                    3'b000:  op = `OP_SB;
                    3'b001:  op = `OP_SH;
                    3'b010:  op = `OP_SW;
                    default: op = `OP_EXIT;
                endcase
            end
            `OPC_IMM: begin
                case (funct3)
                    3'b000: op = `OP_ADDI;
                    3'b010: op = `OP_SLTI;
                    3'b011: op = `OP_SLTIU;
                    3'b100: op = `OP_XORI;
                    3'b110: op = `OP_ORI;
                    3'b111: op = `OP_ANDI;
                    3'b001: op = `OP_SLLI;
                    3'b101: op = alt ? `OP_SRAI : `OP_SRLI;
                endcase
            end
            `OPC_REG: begin
                case (funct3)
                    3'b000: op = alt ? `OP_SUB : `OP_ADD;
                    3'b001: op = `OP_SLL;
                    3'b010: op = `OP_SLT;
                    3'b011: op = `OP_SLTU;
                    3'b100: op = `OP_XOR;
                    3'b101: op = alt ? `OP_SRA : `OP_SRL;
                    3'b110: op = `OP_OR;
                    3'b111: op = `OP_AND;
                endcase
            end
            default: op = `OP_EXIT;
        endcase
    end

    always_comb begin
        if (op <= `OP_JALR) begin
            kind = `KIND_ELSE;
        end else if (op <= `OP_BGEU) begin
            kind = `KIND_BRANCH;
        end else if (op <= `OP_LHU) begin
            kind = `KIND_LOAD;
        end else if (op <= `OP_SW) begin
            kind = `KIND_STORE;
        end else if (op <= `OP_AND) begin
            kind = `KIND_TOREG;
        end else begin
            kind = `KIND_EXIT;
        end
    end

    always_comb begin
        uses_rs1     = 1'b0;
        uses_rs2     = 1'b0;
        to_rs        = 1'b0;
        to_lsb       = 1'b0;
        result_ready = 1'b0;
        result_value = '0;
        dest         = rd;
        rob_jump     = 1'b0;
        next_pc      = pc_plus4;
        case (opcode)
            `OPC_LUI: begin
                result_ready = 1'b1;
                result_value = imm_u;
            end
            `OPC_AUIPC: begin
                result_ready = 1'b1;
                result_value = pc + imm_u;
            end
            `OPC_JAL: begin
                result_ready = 1'b1;
                result_value = pc_plus4;    // link address
                rob_jump     = 1'b1;
                next_pc      = pc + imm_j;
            end
            `OPC_JALR: begin
                uses_rs1     = 1'b1;
                to_rs        = 1'b1;
                result_value = pc_plus4;
                rob_jump     = 1'b1;
            end
            `OPC_BRANCH: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                to_rs    = 1'b1;
                dest     = '0;
                rob_jump = is_jump;
                next_pc  = is_jump ? branch_target : pc_plus4;   // predicted
            end
            `OPC_LOAD: begin
                uses_rs1 = 1'b1;
                to_lsb   = 1'b1;
            end
            `OPC_STORE: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                to_lsb   = 1'b1;
                dest     = '0;
            end
            `OPC_IMM: begin
                uses_rs1 = 1'b1;
                to_rs    = 1'b1;
            end
            `OPC_REG: begin
                uses_rs1 = 1'b1;
                uses_rs2 = 1'b1;
                to_rs    = 1'b1;
            end
            default: ;  // exit goes to the ROB alone
        endcase
    end

endmodule

`default_nettype wire

//--- design/operand_resolve.sv
`timescale 1ns/10ps
`default_nettype none

module operand_resolve
    import rv_decode_pkg::*;
(
    input  logic  uses_rs1,
    input  logic  uses_rs2,
    input  word_t imm_operand,
    input  word_t rf_val1,
    input  word_t rf_val2,
    input  logic  rf_has_rely1,
    input  logic  rf_has_rely2,
    input  logic  rob_id1_ready,
    input  logic  rob_id2_ready,
    input  word_t rob_id1_value,
    input  word_t rob_id2_value,
    output word_t val1,
    output word_t val2,
    output logic  pending1,
    output logic  pending2
);

    word_t src1;
    word_t src2;

    // register file first, then ROB bypass, else still waiting
    assign src1 = !rf_has_rely1 ? rf_val1 : (rob_id1_ready ? rob_id1_value : '0);
    assign src2 = !rf_has_rely2 ? rf_val2 : (rob_id2_ready ? rob_id2_value : '0);

    assign val1 = uses_rs1 ? src1 : '0;
    assign val2 = uses_rs2 ? src2 : imm_operand;   // immediate rides in slot 2

    assign pending1 = uses_rs1 && rf_has_rely1 && !rob_id1_ready;
    assign pending2 = uses_rs2 && rf_has_rely2 && !rob_id2_ready;

endmodule

`default_nettype wire

//--- design/dispatch_stage.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_params.svh"

module dispatch_stage
    import rv_decode_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset,
    input  logic      rob_clear,
    input  logic      if_valid,
    input  word_t     pc,
    input  logic      rob_full,
    input  logic      rs_full,
    input  logic      lsb_full,
    input  rob_idx_t  rob_index,
    input  op_t       op,
    input  rob_kind_t kind,
    input  word_t     store_offset,
    input  logic      to_rs,
    input  logic      to_lsb,
    input  logic      result_ready,
    input  word_t     result_value,
    input  reg_idx_t  dest,
    input  word_t     branch_target,
    input  logic      rob_jump,
    input  word_t     val1,
    input  word_t     val2,
    input  logic      pending1,
    input  logic      pending2,
    input  rob_idx_t  rf_rely1,
    input  rob_idx_t  rf_rely2,
    output logic      stall,
    output logic      dc_valid,
    output logic      rob_inst_valid,
    output logic      rob_inst_ready,
    output op_t       rob_inst_op,
    output rob_kind_t rob_type,
    output word_t     rob_value,
    output reg_idx_t  rob_rd,
    output word_t     rob_inst_pc,
    output word_t     rob_addr,
    output logic      rob_isjump,
    output logic      rs_inst_valid,
    output logic      lsb_inst_valid,
    output op_t       inst_op,
    output rob_idx_t  inst_rob_index,
    output word_t     inst_val1,
    output word_t     inst_val2,
    output logic      inst_has_rely1,
    output logic      inst_has_rely2,
    output rob_idx_t  inst_rely1,
    output rob_idx_t  inst_rely2,
    output word_t     inst_imm
);

    word_t last_pc;
    logic  accept;

    assign stall    = rob_full || rs_full || lsb_full;
    assign accept   = if_valid && !stall && (pc != last_pc);   // drop repeated pc
    assign dc_valid = accept;

    always_ff @(posedge clk_in) begin
        if (reset || rob_clear) begin
            rob_inst_valid <= 1'b0;
            rs_inst_valid  <= 1'b0;
            lsb_inst_valid <= 1'b0;
            last_pc        <= '1;
        end else if (accept) begin
            rob_inst_valid <= 1'b1;
            rs_inst_valid  <= to_rs;
            lsb_inst_valid <= to_lsb;
            last_pc        <= pc;
        end else begin
            rob_inst_valid <= 1'b0;
            rs_inst_valid  <= 1'b0;
            lsb_inst_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_in) begin
        if (accept) begin
            rob_inst_ready <= result_ready;
            rob_inst_op    <= op;
            rob_type       <= kind;
            rob_value      <= result_value;
            rob_rd         <= dest;
            rob_inst_pc    <= pc;
            rob_addr       <= (kind == `KIND_BRANCH) ? branch_target : '0;
            rob_isjump     <= rob_jump;
            inst_op        <= op;
            inst_rob_index <= rob_index;    // slot the ROB hands out
            inst_val1      <= val1;
            inst_val2      <= val2;
            inst_has_rely1 <= pending1;
            inst_has_rely2 <= pending2;
            inst_rely1     <= rf_rely1;
            inst_rely2     <= rf_rely2;
            inst_imm       <= (kind == `KIND_STORE) ? store_offset : '0;
        end
    end

endmodule

`default_nettype wire

//--- design/rv_decoder_top.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder_top
    import rv_decode_pkg::*;
(
    input  logic      clk_in,
    input  logic      reset,
    input  logic      if_valid,
    input  word_t     instr,
    input  word_t     pc,
    input  logic      is_jump,
    output logic      stall,
    output logic      dc_valid,
    output word_t     dc_nextpc,
    output reg_idx_t  rf_rs1,
    output reg_idx_t  rf_rs2,
    input  word_t     rf_val1,
    input  word_t     rf_val2,
    input  logic      rf_has_rely1,
    input  logic      rf_has_rely2,
    input  rob_idx_t  rf_rely1,
    input  rob_idx_t  rf_rely2,
    output rob_idx_t  rob_id1,
    output rob_idx_t  rob_id2,
    input  logic      rob_id1_ready,
    input  logic      rob_id2_ready,
    input  word_t     rob_id1_value,
    input  word_t     rob_id2_value,
    input  logic      rob_clear,
    input  logic      rob_full,
    input  rob_idx_t  rob_index,
    output logic      rob_inst_valid,
    output logic      rob_inst_ready,
    output op_t       rob_inst_op,
    output rob_kind_t rob_type,
    output word_t     rob_value,
    output reg_idx_t  rob_rd,
    output word_t     rob_inst_pc,
    output word_t     rob_addr,
    output logic      rob_isjump,
    input  logic      rs_full,
    output logic      rs_inst_valid,
    input  logic      lsb_full,
    output logic      lsb_inst_valid,
    output op_t       inst_op,
    output rob_idx_t  inst_rob_index,
    output word_t     inst_val1,
    output word_t     inst_val2,
    output logic      inst_has_rely1,
    output logic      inst_has_rely2,
    output rob_idx_t  inst_rely1,
    output rob_idx_t  inst_rely2,
    output word_t     inst_imm
);

    op_t       op;
    rob_kind_t kind;
    reg_idx_t  dest;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      to_rs;
    logic      to_lsb;
    logic      result_ready;
    logic      rob_jump;
    logic      pending1;
    logic      pending2;
    word_t     imm_operand;
    word_t     store_offset;
    word_t     result_value;
    word_t     branch_target;
    word_t     val1;
    word_t     val2;

    // ROB is asked about whatever the register file says we depend on
    assign rob_id1 = rf_rely1;
    assign rob_id2 = rf_rely2;

    field_decode field_decode_i (
        .instr         (instr),
        .pc            (pc),
        .is_jump       (is_jump),
        .rs1           (rf_rs1),
        .rs2           (rf_rs2),
        .rd            (),
        .op            (op),
        .kind          (kind),
        .uses_rs1      (uses_rs1),
        .uses_rs2      (uses_rs2),
        .imm_operand   (imm_operand),
        .store_offset  (store_offset),
        .to_rs         (to_rs),
        .to_lsb        (to_lsb),
        .result_ready  (result_ready),
        .result_value  (result_value),
        .dest          (dest),
        .branch_target (branch_target),
        .rob_jump      (rob_jump),
        .next_pc       (dc_nextpc)
    );

    operand_resolve operand_resolve_i (
        .uses_rs1      (uses_rs1),
        .uses_rs2      (uses_rs2),
        .imm_operand   (imm_operand),
        .rf_val1       (rf_val1),
        .rf_val2       (rf_val2),
        .rf_has_rely1  (rf_has_rely1),
        .rf_has_rely2  (rf_has_rely2),
        .rob_id1_ready (rob_id1_ready),
        .rob_id2_ready (rob_id2_ready),
        .rob_id1_value (rob_id1_value),
        .rob_id2_value (rob_id2_value),
        .val1          (val1),
        .val2          (val2),
        .pending1      (pending1),
        .pending2      (pending2)
    );

    dispatch_stage dispatch_stage_i (
        .clk_in         (clk_in),
        .reset          (reset),
        .rob_clear      (rob_clear),
        .if_valid       (if_valid),
        .pc             (pc),
        .rob_full       (rob_full),
        .rs_full        (rs_full),
        .lsb_full       (lsb_full),
        .rob_index      (rob_index),
        .op             (op),
        .kind           (kind),
        .store_offset   (store_offset),
        .to_rs          (to_rs),
        .to_lsb         (to_lsb),
        .result_ready   (result_ready),
        .result_value   (result_value),
        .dest           (dest),
        .branch_target  (branch_target),
        .rob_jump       (rob_jump),
        .val1           (val1),
        .val2           (val2),
        .pending1       (pending1),
        .pending2       (pending2),
        .rf_rely1       (rf_rely1),
        .rf_rely2       (rf_rely2),
        .stall          (stall),
        .dc_valid       (dc_valid),
        .rob_inst_valid (rob_inst_valid),
        .rob_inst_ready (rob_inst_ready),
        .rob_inst_op    (rob_inst_op),
        .rob_type       (rob_type),
        .rob_value      (rob_value),
        .rob_rd         (rob_rd),
        .rob_inst_pc    (rob_inst_pc),
        .rob_addr       (rob_addr),
        .rob_isjump     (rob_isjump),
        .rs_inst_valid  (rs_inst_valid),
        .lsb_inst_valid (lsb_inst_valid),
        .inst_op        (inst_op),
        .inst_rob_index (inst_rob_index),
        .inst_val1      (inst_val1),
        .inst_val2      (inst_val2),
        .inst_has_rely1 (inst_has_rely1),
        .inst_has_rely2 (inst_has_rely2),
        .inst_rely1     (inst_rely1),
        .inst_rely2     (inst_rely2),
        .inst_imm       (inst_imm)
    );

endmodule

`default_nettype wire

//--- sim/rv_decoder_properties.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decoder_properties
    import rv_decode_pkg::*;
(
    input logic  clk_in,
    input logic  reset,
    input logic  rob_clear,
    input logic  stall,
    input word_t pc,
    input logic  rob_inst_valid,
    input logic  rs_inst_valid,
    input logic  lsb_inst_valid,
    input word_t rob_inst_pc
);

    int fail_count = 0;

    rs_lsb_exclusive: assert property (@(posedge clk_in) disable iff (reset)
        !(rs_inst_valid && lsb_inst_valid))
    else begin
        fail_count++;
        $error("rs and lsb valid together");
    end

    issued_pc: assert property (@(posedge clk_in) disable iff (reset)
        rob_inst_valid |-> rob_inst_pc == $past(pc))
    else begin
        fail_count++;
        $error("issued pc is not the pc of the previous cycle");
    end

    quiet_after_block: assert property (@(posedge clk_in) disable iff (reset)
        (stall || rob_clear) |=> !(rob_inst_valid || rs_inst_valid || lsb_inst_valid))
    else begin
        fail_count++;
        $error("valid raised after stall or rob clear");
    end

endmodule

`default_nettype wire

//--- sim/rv_decoder_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "rv_decode_params.svh"

module rv_decoder_tb
    import rv_decode_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int NUM_INSTR  = 80;

    logic      clk_in = 1'b0;
    logic      reset;
    logic      if_valid;
    word_t     instr;
    word_t     pc;
    logic      is_jump;
    logic      stall;
    logic      dc_valid;
    word_t     dc_nextpc;
    reg_idx_t  rf_rs1;
    reg_idx_t  rf_rs2;
    word_t     rf_val1;
    word_t     rf_val2;
    logic      rf_has_rely1;
    logic      rf_has_rely2;
    rob_idx_t  rf_rely1;
    rob_idx_t  rf_rely2;
    rob_idx_t  rob_id1;
    rob_idx_t  rob_id2;
    logic      rob_id1_ready;
    logic      rob_id2_ready;
    word_t     rob_id1_value;
    word_t     rob_id2_value;
    logic      rob_clear;
    logic      rob_full;
    rob_idx_t  rob_index;
    logic      rob_inst_valid;
    logic      rob_inst_ready;
    op_t       rob_inst_op;
    rob_kind_t rob_type;
    word_t     rob_value;
    reg_idx_t  rob_rd;
    word_t     rob_inst_pc;
    word_t     rob_addr;
    logic      rob_isjump;
    logic      rs_full;
    logic      rs_inst_valid;
    logic      lsb_full;
    logic      lsb_inst_valid;
    op_t       inst_op;
    rob_idx_t  inst_rob_index;
    word_t     inst_val1;
    word_t     inst_val2;
    logic      inst_has_rely1;
    logic      inst_has_rely2;
    rob_idx_t  inst_rely1;
    rob_idx_t  inst_rely2;
    word_t     inst_imm;

    logic [31:0] lfsr = 32'he7f7_478f;
    word_t       seen_nextpc;
    int          checks = 0;
    int          errors = 0;
    int          test_start = 0;

    rv_decoder_top rv_decoder_top_i (.*);

    bind rv_decoder_top rv_decoder_properties rv_decoder_properties_i (.*);

    always #(CLK_PERIOD / 2) clk_in = ~clk_in;

    // taps 32 22 2 1 stepped once per bit
    function automatic logic [31:0] next_bits(input int n);
        logic [31:0] r;
        logic        fb;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic word_t sext(input word_t v, input int bits);
        return v[bits-1] ? (v | (~32'd0 << bits)) : v;
    endfunction

    function automatic word_t enc_u(input word_t imm, input word_t rd, input logic [6:0] opc);
        return {imm[19:0], rd[4:0], opc};
    endfunction

    function automatic word_t enc_j(input word_t off, input word_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd[4:0], `OPC_JAL};
    endfunction

    function automatic word_t enc_i(input word_t imm, input word_t rs1, input logic [2:0] f3,
                                    input word_t rd, input logic [6:0] opc);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], opc};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input word_t rs2, input word_t rs1,
                                    input logic [2:0] f3, input word_t rd);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_REG};
    endfunction

    function automatic word_t enc_s(input word_t off, input word_t rs2, input word_t rs1);
        return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], `OPC_STORE};
    endfunction

    function automatic word_t enc_b(input word_t off, input word_t rs2, input word_t rs1);
        return {off[12], off[10:5], rs2[4:0], rs1[4:0], 3'b001, off[4:1], off[11], `OPC_BRANCH};
    endfunction

    // register file value, else ready ROB entry, else zero
    function automatic word_t pick(input logic used, input logic has, input logic rdy,
                                   input word_t rf, input word_t rob, input word_t unused);
        if (!used) begin
            return unused;
        end
        if (!has) begin
            return rf;
        end
        return rdy ? rob : '0;
    endfunction

    task automatic check(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic test_done(input string name);
        $display("test %-10s %s (%0d errors)", name,
                 (errors == test_start) ? "ok" : "FAILED", errors - test_start);
        test_start = errors;
    endtask

    task automatic wait_issue();
        int n;
        n = 0;
        @(negedge clk_in);
        while (!rob_inst_valid && n < 4) begin
            @(negedge clk_in);
            n++;
        end
        assert (rob_inst_valid) else begin
            errors++;
            $display("no issue seen for pc %h within %0d cycles", pc, n + 1);
        end
        check("rob_inst_pc", rob_inst_pc, pc);
    endtask

    // dep is {has_rely1, rob1_ready, has_rely2, rob2_ready}
    task automatic issue(input word_t ins, input logic jmp, input logic [3:0] dep);
        @(posedge clk_in);
        instr         <= ins;
        pc            <= pc + 32'd4;
        is_jump       <= jmp;
        if_valid      <= 1'b1;
        rf_val1       <= next_bits(32);
        rf_val2       <= next_bits(32);
        rob_id1_value <= next_bits(32);
        rob_id2_value <= next_bits(32);
        rf_has_rely1  <= dep[3];
        rob_id1_ready <= dep[2];
        rf_has_rely2  <= dep[1];
        rob_id2_ready <= dep[0];
        rf_rely1      <= rob_idx_t'(next_bits(`ROB_ADDR_W));
        rf_rely2      <= rob_idx_t'(next_bits(`ROB_ADDR_W));
        rob_index     <= rob_idx_t'(next_bits(`ROB_ADDR_W));
        @(negedge clk_in);
        seen_nextpc = dc_nextpc;
        check_bit("dc_valid", dc_valid, 1'b1);
        @(posedge clk_in);
        if_valid <= 1'b0;
        wait_issue();
    endtask

    task automatic check_operands(input logic use2, input word_t imm);
        check("inst_val1", inst_val1,
              pick(1'b1, rf_has_rely1, rob_id1_ready, rf_val1, rob_id1_value, '0));
        check("inst_val2", inst_val2,
              pick(use2, rf_has_rely2, rob_id2_ready, rf_val2, rob_id2_value, imm));
        check_bit("inst_has_rely1", inst_has_rely1, rf_has_rely1 && !rob_id1_ready);
        check_bit("inst_has_rely2", inst_has_rely2, use2 && rf_has_rely2 && !rob_id2_ready);
        check("inst_rely1", 32'(inst_rely1), 32'(rf_rely1));
        check("inst_rely2", 32'(inst_rely2), 32'(rf_rely2));
        check("rob_id1", 32'(rob_id1), 32'(rf_rely1));
        check("rob_id2", 32'(rob_id2), 32'(rf_rely2));
        check("inst_rob_index", 32'(inst_rob_index), 32'(rob_index));
        check_bit("rs_inst_valid", rs_inst_valid, 1'b1);
        check_bit("lsb_inst_valid", lsb_inst_valid, 1'b0);
        check("rob_type", 32'(rob_type), 32'(`KIND_TOREG));
    endtask

    initial begin
        #(NUM_INSTR * 20 * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", NUM_INSTR * 20);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        int    k;
        int    issued;
        int    total;
        word_t ra;
        word_t rb;
        word_t imm;
        reset         = 1'b1;
        if_valid      = 1'b0;
        instr         = '0;
        pc            = 32'h0000_1000;
        is_jump       = 1'b0;
        rf_val1       = '0;
        rf_val2       = '0;
        rf_has_rely1  = 1'b0;
        rf_has_rely2  = 1'b0;
        rf_rely1      = '0;
        rf_rely2      = '0;
        rob_id1_ready = 1'b0;
        rob_id2_ready = 1'b0;
        rob_id1_value = '0;
        rob_id2_value = '0;
        rob_clear     = 1'b0;
        rob_full      = 1'b0;
        rs_full       = 1'b0;
        lsb_full      = 1'b0;
        rob_index     = '0;
        repeat (5) @(posedge clk_in);
        reset <= 1'b0;

        for (k = 0; k < 4; k++) begin
            imm = next_bits(20);
            ra  = next_bits(5);
            issue(enc_u(imm, ra, `OPC_LUI), 1'b0, 4'b0);
            check("rob_value", rob_value, {imm[19:0], 12'b0});
            check_bit("rob_inst_ready", rob_inst_ready, 1'b1);
            check_bit("rs_inst_valid", rs_inst_valid, 1'b0);
            check_bit("lsb_inst_valid", lsb_inst_valid, 1'b0);
            check("rob_rd", 32'(rob_rd), ra);
            issue(enc_u(imm, ra, `OPC_AUIPC), 1'b0, 4'b0);
            check("rob_value", rob_value, pc + {imm[19:0], 12'b0});
            check("rob_inst_op", 32'(rob_inst_op), 32'(`OP_AUIPC));
            imm = next_bits(20) << 1;   // J offset
            issue(enc_j(imm, ra), 1'b0, 4'b0);
            check("dc_nextpc", seen_nextpc, pc + sext(imm, 21));
            check("rob_value", rob_value, pc + 32'd4);
            check_bit("rob_inst_ready", rob_inst_ready, 1'b1);
            check_bit("rob_isjump", rob_isjump, 1'b1);
            check_bit("rs_inst_valid", rs_inst_valid, 1'b0);
        end
        test_done("upper/jal");

        for (k = 0; k < 16; k++) begin
            ra = next_bits(5);
            rb = next_bits(5);
            issue(enc_r({1'b0, k[0], 5'b0}, rb, ra, 3'b000, next_bits(5)), 1'b0, 4'(k));
            check("inst_op", 32'(inst_op), k[0] ? 32'(`OP_SUB) : 32'(`OP_ADD));
            check("rf_rs1", 32'(rf_rs1), ra);
            check("rf_rs2", 32'(rf_rs2), rb);
            check_operands(1'b1, '0);
            imm = next_bits(12);
            issue(enc_i(imm, ra, 3'b000, rb, `OPC_IMM), 1'b0, 4'(k));
            check("inst_op", 32'(inst_op), 32'(`OP_ADDI));
            check_operands(1'b0, sext(imm, 12));
        end
        imm = next_bits(5);
        issue(enc_i(imm, next_bits(5), 3'b001, next_bits(5), `OPC_IMM), 1'b0, 4'b0);
        check_operands(1'b0, imm);
        issue(enc_i(imm | 32'h400, next_bits(5), 3'b101, next_bits(5), `OPC_IMM), 1'b0, 4'b0);
        check("inst_op", 32'(inst_op), 32'(`OP_SRAI));
        check_operands(1'b0, imm);     // shamt without the sra bit
        test_done("alu");

        for (k = 0; k < 4; k++) begin
            imm = next_bits(12);
            ra  = next_bits(5);
            issue(enc_i(imm, next_bits(5), 3'b010, ra, `OPC_LOAD), 1'b0, 4'b0);
            check_bit("lsb_inst_valid", lsb_inst_valid, 1'b1);
            check_bit("rs_inst_valid", rs_inst_valid, 1'b0);
            check("rob_rd", 32'(rob_rd), ra);
            check("inst_op", 32'(inst_op), 32'(`OP_LW));
            check("inst_imm", inst_imm, '0);
            issue(enc_s(imm, next_bits(5), next_bits(5)), 1'b0, 4'b0);
            check_bit("lsb_inst_valid", lsb_inst_valid, 1'b1);
            check("inst_imm", inst_imm, sext(imm, 12));
            check("rob_rd", 32'(rob_rd), '0);
            check("rob_type", 32'(rob_type), 32'(`KIND_STORE));
        end
        test_done("load/store");

        for (k = 0; k < 8; k++) begin
            imm = next_bits(12) << 1;   // B offset
            issue(enc_b(imm, next_bits(5), next_bits(5)), k[0], 4'b0);
            check_bit("rs_inst_valid", rs_inst_valid, 1'b1);
            check("rob_addr", rob_addr, pc + sext(imm, 13));
            check_bit("rob_isjump", rob_isjump, k[0]);
            check("dc_nextpc", seen_nextpc, k[0] ? pc + sext(imm, 13) : pc + 32'd4);
            check("rob_rd", 32'(rob_rd), '0);
            check("rob_inst_op", 32'(rob_inst_op), 32'(`OP_BNE));
        end
        test_done("branch");

        for (k = 0; k < 3; k++) begin
            @(posedge clk_in);
            instr    <= enc_i(next_bits(12), next_bits(5), 3'b000, next_bits(5), `OPC_IMM);
            pc       <= pc + 32'd4;
            if_valid <= 1'b1;
            rob_full <= (k == 0);
            rs_full  <= (k == 1);
            lsb_full <= (k == 2);
            @(negedge clk_in);
            check_bit("stall", stall, 1'b1);
            check_bit("dc_valid", dc_valid, 1'b0);
            @(posedge clk_in);
            rob_full <= 1'b0;
            rs_full  <= 1'b0;
            lsb_full <= 1'b0;
            @(negedge clk_in);
            check_bit("rob_inst_valid", rob_inst_valid, 1'b0);
            check_bit("dc_valid", dc_valid, 1'b1);   // fetch held its instruction
            @(posedge clk_in);
            if_valid <= 1'b0;
            wait_issue();
        end
        test_done("full");

        issued = 0;
        @(posedge clk_in);
        pc       <= pc + 32'd4;
        if_valid <= 1'b1;
        for (k = 0; k < 4; k++) begin
            @(posedge clk_in);
            if (k == 2) begin
                if_valid <= 1'b0;
            end
            @(negedge clk_in);
            if (rob_inst_valid) begin
                issued++;
            end
        end
        check("issue count", 32'(issued), 32'd1);
        @(posedge clk_in);
        pc        <= pc + 32'd4;
        if_valid  <= 1'b1;
        rob_clear <= 1'b1;
        @(posedge clk_in);
        if_valid  <= 1'b0;
        rob_clear <= 1'b0;
        @(negedge clk_in);
        check_bit("rob_inst_valid", rob_inst_valid, 1'b0);
        @(posedge clk_in);
        if_valid <= 1'b1;   // same pc again after the flush
        @(posedge clk_in);
        if_valid <= 1'b0;
        wait_issue();
        test_done("dup/clear");

        total = errors + rv_decoder_top_i.rv_decoder_properties_i.fail_count;
        $display("checks %0d, check errors %0d, property failures %0d", checks, errors,
                 rv_decoder_top_i.rv_decoder_properties_i.fail_count);
        if (total == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+design
design/rv_decode_pkg.sv
design/field_decode.sv
design/operand_resolve.sv
design/dispatch_stage.sv
design/rv_decoder_top.sv
sim/rv_decoder_properties.sv
sim/rv_decoder_tb.sv

//--- Makefile
TOP = rv_decoder_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sources.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) +verilator+error+limit+100 | tee sim.log
	grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log
